//--- logic/arm_decode_pkg.sv
`default_nettype none

package arm_decode_pkg;

        // Field widths of the 32-bit instruction word
        localparam int WORD_W      = 32;
        localparam int COND_W      = 4;
        localparam int REG_W       = 4;
        localparam int ALU_OP_W    = 4;
        localparam int SHIFT_W     = 3;
        localparam int BR_OFFSET_W = 24;

        typedef logic [WORD_W-1:0] word_t;
        typedef logic [REG_W-1:0]  reg_idx_t;

        typedef enum logic [COND_W-1:0] {
                EQ = 4'h0,
                NE = 4'h1,
                CS = 4'h2,
                CC = 4'h3,
                MI = 4'h4,
                PL = 4'h5,
                VS = 4'h6,
                VC = 4'h7,
                HI = 4'h8,
                LS = 4'h9,
                GE = 4'ha,
                LT = 4'hb,
                GT = 4'hc,
                LE = 4'hd,
                AL = 4'he,
                NV = 4'hf
        } arm_cond_t;

        // Values 12 to 15 are never produced
        typedef enum logic [3:0] {
                DATAPROC      = 4'd0,
                MULTIPLY      = 4'd1,
                MULTIPLY_LONG = 4'd2,
                SWAP          = 4'd3,
                SINGLE_XFER   = 4'd4,
                HALFWORD_XFER = 4'd5,
                BLOCK_XFER    = 4'd6,
                BRANCH        = 4'd7,
                BRANCH_EX     = 4'd8,
                SWI           = 4'd9,
                PSR_XFER      = 4'd10,
                UNDEF         = 4'd11
        } arm_class_t;

        // Data processing layout, bits 27..26 are the class bits
        typedef struct packed {
                arm_cond_t             cond;
                logic [1:0]            class_bits;
                logic                  imm;
                logic [ALU_OP_W-1:0]   alu_op;
                logic                  set_flags;
                reg_idx_t              rn;
                reg_idx_t              rd;
                reg_idx_t              rs;
                logic [SHIFT_W-1:0]    shift;
                logic                  flag;
                reg_idx_t              rm;
        } dp_view_t;

        // Branch layout, bits 27..25 are 101
        typedef struct packed {
                arm_cond_t               cond;
                logic [2:0]              class_bits;
                logic                    link;
                logic [BR_OFFSET_W-1:0]  offset;
        } branch_view_t;

        typedef union packed {
                dp_view_t     dp;
                branch_view_t br;
        } arm_instr_u;

endpackage

`default_nettype wire

//--- logic/fetch_unit.sv
`default_nettype none

module fetch_unit
        import arm_decode_pkg::*;
#(
        parameter int    QUEUE_DEPTH = 4,
        parameter word_t RESET_PC    = '0
) (
        input  logic                               clk,
        input  logic                               reset,
        input  logic                               fetch_valid,
        input  word_t                              fetch_data,
        input  logic [$clog2(QUEUE_DEPTH + 1)-1:0] free,
        output logic                               fetch_req,
        output word_t                              fetch_addr,
        output logic                               push,
        output word_t                              push_pc,
        output word_t                              push_instr
);

        localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

        word_t            pc;
        word_t            flight_pc;
        logic             in_flight;
        logic [CNT_W-1:0] pending;
        logic             issue;

        // Words not yet counted in free: the request on the bus and
        // the answer arriving this cycle
        assign pending = CNT_W'(fetch_req) + CNT_W'(in_flight);
        assign issue   = free > pending;

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        pc        <= RESET_PC;
                        fetch_req <= 1'b0;
                        in_flight <= 1'b0;
                end else begin
                        fetch_req <= issue;
                        in_flight <= fetch_req;
                        if (fetch_req) begin
                                pc <= pc + 32'd4;
                        end
                end
        end

        // Address of the request now being answered
        always_ff @(posedge clk) begin
                if (fetch_req) begin
                        flight_pc <= pc;
                end
        end

        assign fetch_addr = pc;

        // Returned word goes straight into the queue
        assign push       = fetch_valid;
        assign push_pc    = flight_pc;
        assign push_instr = fetch_data;

        // Memory answers only what was asked one cycle before
        a_valid_needs_request: assert property (
                @(posedge clk) disable iff (reset)
                fetch_valid |-> in_flight
        ) else $error("fetch_valid without a request in flight");

endmodule

`default_nettype wire

//--- logic/instr_queue.sv
`default_nettype none

module instr_queue
        import arm_decode_pkg::*;
#(
        parameter int QUEUE_DEPTH = 4
) (
        input  logic                               clk,
        input  logic                               reset,
        input  logic                               push,
        input  word_t                              push_pc,
        input  word_t                              push_instr,
        input  logic                               pop,
        output logic                               empty,
        output logic [$clog2(QUEUE_DEPTH + 1)-1:0] free,
        output word_t                              head_pc,
        output word_t                              head_instr
);

        localparam int PTR_W = $clog2(QUEUE_DEPTH);
        localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

        word_t            pc_mem    [QUEUE_DEPTH];
        word_t            instr_mem [QUEUE_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;

        // Storage, written on every push
        always_ff @(posedge clk) begin
                if (push) begin
                        pc_mem[wr_ptr]    <= push_pc;
                        instr_mem[wr_ptr] <= push_instr;
                end
        end

        // Pointers wrap on their own since the depth is a power of two
        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({push, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        assign empty      = (count == '0);
        assign free       = CNT_W'(QUEUE_DEPTH) - count;

        // Show-ahead head entry
        assign head_pc    = pc_mem[rd_ptr];
        assign head_instr = instr_mem[rd_ptr];

        // Fetch must hold back before the queue fills
        a_no_overflow: assert property (
                @(posedge clk) disable iff (reset)
                push |-> (count != CNT_W'(QUEUE_DEPTH))
        ) else $error("push into a full queue");

        a_no_underflow: assert property (
                @(posedge clk) disable iff (reset)
                pop |-> !empty
        ) else $error("pop from an empty queue");

endmodule

`default_nettype wire

//--- logic/arm_decoder.sv
`default_nettype none

module arm_decoder
        import arm_decode_pkg::*;
(
        input  logic                clk,
        input  logic                reset,
        input  logic                empty,
        input  logic                decode_stall,
        input  word_t               head_pc,
        input  word_t               head_instr,
        output logic                pop,
        output logic                dec_valid,
        output word_t               dec_pc,
        output arm_cond_t           dec_cond,
        output arm_class_t          dec_class,
        output reg_idx_t            dec_rn,
        output reg_idx_t            dec_rd,
        output reg_idx_t            dec_rs,
        output reg_idx_t            dec_rm,
        output logic                dec_imm,
        output logic [ALU_OP_W-1:0] dec_alu_op,
        output logic                dec_set_flags,
        output logic                dec_link,
        output word_t               dec_offset
);

        arm_instr_u          instr;
        arm_class_t          cls;
        logic [ALU_OP_W-1:0] alu_op;
        logic                imm;
        logic                set_flags;
        logic                link;
        word_t               offset;

        // Priority order matters, earlier patterns shadow later ones
        function automatic arm_class_t classify(word_t w);
                priority casez (w)
                        32'b????_0001_0010_1111_1111_1111_0001_????: return BRANCH_EX;
                        32'b????_100?_????_????_????_????_????_????: return BLOCK_XFER;
                        32'b????_101?_????_????_????_????_????_????: return BRANCH;
                        32'b????_1111_????_????_????_????_????_????: return SWI;
                        // Media space with bit 4 set
                        32'b????_011?_????_????_????_????_???1_????: return UNDEF;
                        32'b????_01??_????_????_????_????_????_????: return SINGLE_XFER;
                        32'b????_0001_0?00_????_????_0000_1001_????: return SWAP;
                        32'b????_0000_0???_????_????_????_1001_????: return MULTIPLY;
                        32'b????_0000_1???_????_????_????_1001_????: return MULTIPLY_LONG;
                        32'b????_000?_????_????_????_????_1??1_????: return HALFWORD_XFER;
                        32'b????_00?1_0??0_????_????_????_????_????: return PSR_XFER;
                        32'b????_00??_????_????_????_????_????_????: return DATAPROC;
                        // Coprocessor and anything left
                        default:                                     return UNDEF;
                endcase
        endfunction

        assign instr = head_instr;
        assign cls   = classify(head_instr);

        // Consume the head whenever something is there and no stall
        assign pop = !empty && !decode_stall;

        always_comb begin
                alu_op    = '0;
                imm       = 1'b0;
                set_flags = 1'b0;
                link      = 1'b0;
                offset    = '0;
                if (cls == DATAPROC) begin
                        alu_op    = instr.dp.alu_op;
                        imm       = instr.dp.imm;
                        set_flags = instr.dp.set_flags;
                end
                if (cls == BRANCH) begin
                        link   = instr.br.link;
                        // Word offset, sign extended and turned into bytes
                        offset = {{(WORD_W - BR_OFFSET_W - 2){instr.br.offset[BR_OFFSET_W-1]}},
                                  instr.br.offset, 2'b00};
                end
        end

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        dec_valid <= 1'b0;
                end else begin
                        dec_valid <= pop;
                end
        end

        // Decoded fields, loaded with each pop
        always_ff @(posedge clk) begin
                if (pop) begin
                        dec_pc        <= head_pc;
                        dec_cond      <= instr.dp.cond;
                        dec_class     <= cls;
                        dec_rn        <= instr.dp.rn;
                        dec_rd        <= instr.dp.rd;
                        dec_rs        <= instr.dp.rs;
                        dec_rm        <= instr.dp.rm;
                        dec_imm       <= imm;
                        dec_alu_op    <= alu_op;
                        dec_set_flags <= set_flags;
                        dec_link      <= link;
                        dec_offset    <= offset;
                end
        end

        // A valid output always carries one of the twelve classes
        a_class_in_range: assert property (
                @(posedge clk) disable iff (reset)
                dec_valid |-> (!$isunknown(dec_class) && dec_class <= UNDEF)
        ) else $error("dec_class out of range");

endmodule

`default_nettype wire

//--- logic/decode_frontend.sv
`default_nettype none

module decode_frontend
        import arm_decode_pkg::*;
#(
        parameter int    QUEUE_DEPTH = 4,
        parameter word_t RESET_PC    = '0
) (
        input  logic                clk,
        input  logic                reset,
        output logic                fetch_req,
        output word_t               fetch_addr,
        input  logic                fetch_valid,
        input  word_t               fetch_data,
        input  logic                decode_stall,
        output logic                dec_valid,
        output word_t               dec_pc,
        output arm_cond_t           dec_cond,
        output arm_class_t          dec_class,
        output reg_idx_t            dec_rn,
        output reg_idx_t            dec_rd,
        output reg_idx_t            dec_rs,
        output reg_idx_t            dec_rm,
        output logic                dec_imm,
        output logic [ALU_OP_W-1:0] dec_alu_op,
        output logic                dec_set_flags,
        output logic                dec_link,
        output word_t               dec_offset
);

        // Fetch to queue
        logic                               push;
        word_t                              push_pc;
        word_t                              push_instr;
        logic [$clog2(QUEUE_DEPTH + 1)-1:0] free;

        // Queue to decoder
        logic  empty;
        logic  pop;
        word_t head_pc;
        word_t head_instr;

        fetch_unit #(
                .QUEUE_DEPTH (QUEUE_DEPTH),
                .RESET_PC    (RESET_PC)
        ) u_fetch (
                .clk         (clk),
                .reset       (reset),
                .fetch_valid (fetch_valid),
                .fetch_data  (fetch_data),
                .free        (free),
                .fetch_req   (fetch_req),
                .fetch_addr  (fetch_addr),
                .push        (push),
                .push_pc     (push_pc),
                .push_instr  (push_instr)
        );

        instr_queue #(
                .QUEUE_DEPTH (QUEUE_DEPTH)
        ) u_queue (
                .clk         (clk),
                .reset       (reset),
                .push        (push),
                .push_pc     (push_pc),
                .push_instr  (push_instr),
                .pop         (pop),
                .empty       (empty),
                .free        (free),
                .head_pc     (head_pc),
                .head_instr  (head_instr)
        );

        arm_decoder u_decoder (
                .clk           (clk),
                .reset         (reset),
                .empty         (empty),
                .decode_stall  (decode_stall),
                .head_pc       (head_pc),
                .head_instr    (head_instr),
                .pop           (pop),
                .dec_valid     (dec_valid),
                .dec_pc        (dec_pc),
                .dec_cond      (dec_cond),
                .dec_class     (dec_class),
                .dec_rn        (dec_rn),
                .dec_rd        (dec_rd),
                .dec_rs        (dec_rs),
                .dec_rm        (dec_rm),
                .dec_imm       (dec_imm),
                .dec_alu_op    (dec_alu_op),
                .dec_set_flags (dec_set_flags),
                .dec_link      (dec_link),
                .dec_offset    (dec_offset)
        );

endmodule

`default_nettype wire

//--- verification/decode_frontend_tb.sv
`default_nettype none

module decode_frontend_tb
        import arm_decode_pkg::*;
();

        localparam int    QUEUE_DEPTH    = 4;
        localparam word_t RESET_PC       = 32'h0000_0000;
        localparam int    NUM_ROWS       = 24;
        localparam int    STALL_CYCLES   = 20;
        localparam int    TIMEOUT_CYCLES = NUM_ROWS * 8 + 50;
        localparam word_t NOP_WORD       = 32'hE1A0_0000;
        localparam word_t LFSR_SEED      = 32'h7016_5a5e;

        // Expected decode of one word, fields are cond, rn, rd, rs, rm
        typedef struct packed {
                word_t               instr;
                arm_class_t          cls;
                logic [19:0]         fields;
                logic [ALU_OP_W-1:0] alu_op;
                logic                imm;
                logic                set_flags;
                logic                link;
                word_t               offset;
        } row_t;

        logic                clk;
        logic                reset;
        logic                fetch_req;
        word_t               fetch_addr;
        logic                fetch_valid;
        word_t               fetch_data;
        logic                decode_stall;
        logic                dec_valid;
        word_t               dec_pc;
        arm_cond_t           dec_cond;
        arm_class_t          dec_class;
        reg_idx_t            dec_rn;
        reg_idx_t            dec_rd;
        reg_idx_t            dec_rs;
        reg_idx_t            dec_rm;
        logic                dec_imm;
        logic [ALU_OP_W-1:0] dec_alu_op;
        logic                dec_set_flags;
        logic                dec_link;
        word_t               dec_offset;

        row_t  table_rows [NUM_ROWS];
        row_t  nop_row;
        int    row_count;
        int    cycle_count;
        int    check_count;
        int    error_count;
        int    stall_reqs;
        logic  hold_stall;
        logic  req_seen;
        word_t addr_seen;
        word_t exp_fetch_addr;
        word_t exp_pc;
        word_t lfsr;

        decode_frontend #(
                .QUEUE_DEPTH (QUEUE_DEPTH),
                .RESET_PC    (RESET_PC)
        ) uut (
                .clk           (clk),
                .reset         (reset),
                .fetch_req     (fetch_req),
                .fetch_addr    (fetch_addr),
                .fetch_valid   (fetch_valid),
                .fetch_data    (fetch_data),
                .decode_stall  (decode_stall),
                .dec_valid     (dec_valid),
                .dec_pc        (dec_pc),
                .dec_cond      (dec_cond),
                .dec_class     (dec_class),
                .dec_rn        (dec_rn),
                .dec_rd        (dec_rd),
                .dec_rs        (dec_rs),
                .dec_rm        (dec_rm),
                .dec_imm       (dec_imm),
                .dec_alu_op    (dec_alu_op),
                .dec_set_flags (dec_set_flags),
                .dec_link      (dec_link),
                .dec_offset    (dec_offset)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        function automatic row_t make_row(word_t instr, arm_class_t cls, logic [19:0] fields,
                                          logic [3:0] alu_op, logic imm, logic set_flags,
                                          logic link, word_t offset);
                row_t r;
                r.instr     = instr;
                r.cls       = cls;
                r.fields    = fields;
                r.alu_op    = alu_op;
                r.imm       = imm;
                r.set_flags = set_flags;
                r.link      = link;
                r.offset    = offset;
                return r;
        endfunction

        task automatic add_row(word_t instr, arm_class_t cls, logic [19:0] fields,
                               logic [3:0] alu_op, logic imm, logic set_flags,
                               logic link, word_t offset);
                table_rows[row_count] = make_row(instr, cls, fields, alu_op, imm, set_flags,
                                                 link, offset);
                row_count++;
        endtask

        task automatic load_table();
                row_count = 0;
                add_row(32'hE081_2003, DATAPROC,      20'hE1203, 4'h4, 0, 0, 0, 32'h0);
                add_row(32'hE3A0_0001, DATAPROC,      20'hE0001, 4'hD, 1, 0, 0, 32'h0);
                add_row(32'hE253_3001, DATAPROC,      20'hE3301, 4'h2, 1, 1, 0, 32'h0);
                add_row(32'h0152_0003, DATAPROC,      20'h02003, 4'hA, 0, 1, 0, 32'h0);
                add_row(32'hE10F_0000, PSR_XFER,      20'hEF000, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE128_F000, PSR_XFER,      20'hE8F00, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE12F_FF1E, BRANCH_EX,     20'hEFFFE, 4'h0, 0, 0, 0, 32'h0);
                // One bit off the exchange pattern
                add_row(32'hE12F_FF3E, PSR_XFER,      20'hEFFFE, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE000_0291, MULTIPLY,      20'hE0021, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE032_1394, MULTIPLY,      20'hE2134, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE081_0392, MULTIPLY_LONG, 20'hE1032, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE0E5_4697, MULTIPLY_LONG, 20'hE5467, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE102_0091, SWAP,          20'hE2001, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE144_3095, SWAP,          20'hE4305, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE1D2_10B4, HALFWORD_XFER, 20'hE2104, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE182_30B1, HALFWORD_XFER, 20'hE2301, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE591_0004, SINGLE_XFER,   20'hE1004, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE791_2103, SINGLE_XFER,   20'hE1213, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE7F0_00F0, UNDEF,         20'hE0000, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hEE01_0F10, UNDEF,         20'hE10F0, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hE8BD_4010, BLOCK_XFER,    20'hED400, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hEF00_0011, SWI,           20'hE0001, 4'h0, 0, 0, 0, 32'h0);
                add_row(32'hEA00_0004, BRANCH,        20'hE0004, 4'h0, 0, 0, 0, 32'h10);
                add_row(32'hEBFF_FFFE, BRANCH,        20'hEFFFE, 4'h0, 0, 0, 1, 32'hFFFF_FFF8);
                nop_row = make_row(NOP_WORD, DATAPROC, 20'hE0000, 4'hD, 0, 0, 0, 32'h0);
        endtask

        // Program memory, NOPs past the table
        function automatic word_t mem_word(word_t addr);
                word_t idx;
                idx = (addr - RESET_PC) >> 2;
                if (idx < NUM_ROWS) begin
                        return table_rows[idx].instr;
                end
                return NOP_WORD;
        endfunction

        function automatic word_t lfsr_step(word_t s);
                if (s[0]) begin
                        return (s >> 1) ^ 32'h8020_0003;
                end
                return s >> 1;
        endfunction

        task automatic check_value(string what, word_t got, word_t exp);
                check_count++;
                assert (got === exp) else begin
                        error_count++;
                        $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
                end
        endtask

        // One clock: memory answer, fetch address check, new stall bit
        task automatic step();
                @(posedge clk);
                #1;
                cycle_count++;
                if (cycle_count > TIMEOUT_CYCLES) begin
                        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                        $display("Testbench failed");
                        $finish;
                end else begin
                        fetch_valid = req_seen;
                        fetch_data  = req_seen ? mem_word(addr_seen) : '0;
                        req_seen    = fetch_req;
                        addr_seen   = fetch_addr;
                        if (fetch_req) begin
                                check_value("fetch_addr", fetch_addr, exp_fetch_addr);
                                exp_fetch_addr += 32'd4;
                                if (hold_stall) begin
                                        stall_reqs++;
                                end
                        end
                        lfsr         = lfsr_step(lfsr);
                        decode_stall = hold_stall || lfsr[0];
                end
        endtask

        task automatic wait_decoded();
                step();
                while (!dec_valid) begin
                        step();
                end
        endtask

        task automatic check_output(word_t pc, row_t r);
                check_value("dec_pc", dec_pc, pc);
                check_value("dec_class", dec_class, r.cls);
                check_value("dec_cond", dec_cond, r.fields[19:16]);
                check_value("dec_rn", dec_rn, r.fields[15:12]);
                check_value("dec_rd", dec_rd, r.fields[11:8]);
                check_value("dec_rs", dec_rs, r.fields[7:4]);
                check_value("dec_rm", dec_rm, r.fields[3:0]);
                check_value("dec_alu_op", dec_alu_op, r.alu_op);
                check_value("dec_imm", dec_imm, r.imm);
                check_value("dec_set_flags", dec_set_flags, r.set_flags);
                check_value("dec_link", dec_link, r.link);
                check_value("dec_offset", dec_offset, r.offset);
        endtask

        initial begin
                reset          = 1'b1;
                fetch_valid    = 1'b0;
                fetch_data     = '0;
                decode_stall   = 1'b0;
                hold_stall     = 1'b0;
                req_seen       = 1'b0;
                addr_seen      = '0;
                cycle_count    = 0;
                check_count    = 0;
                error_count    = 0;
                stall_reqs     = 0;
                lfsr           = LFSR_SEED;
                exp_fetch_addr = RESET_PC;
                load_table();

                repeat (2) begin
                        step();
                        check_value("fetch_req in reset", fetch_req, 0);
                        check_value("dec_valid in reset", dec_valid, 0);
                        check_value("fetch_addr in reset", fetch_addr, RESET_PC);
                end
                reset = 1'b0;

                // Whole table under random stalls
                for (int i = 0; i < NUM_ROWS; i++) begin
                        wait_decoded();
                        check_output(RESET_PC + 32'(4 * i), table_rows[i]);
                end
                exp_pc = RESET_PC + 32'(4 * NUM_ROWS);

                // Long stall, the queue fills and fetch stops
                hold_stall = 1'b1;
                step();
                if (dec_valid) begin
                        check_output(exp_pc, nop_row);
                        exp_pc += 32'd4;
                end
                for (int i = 1; i < STALL_CYCLES; i++) begin
                        step();
                        check_value("dec_valid during stall", dec_valid, 0);
                end
                check_value("fetch_req at end of stall", fetch_req, 0);
                check_count++;
                assert (stall_reqs <= QUEUE_DEPTH) else begin
                        error_count++;
                        $display("error at %0t: %0d requests during stall, limit %0d",
                                 $time, stall_reqs, QUEUE_DEPTH);
                end
                hold_stall = 1'b0;

                // Decoding resumes in order
                for (int i = 0; i < QUEUE_DEPTH + 2; i++) begin
                        wait_decoded();
                        check_output(exp_pc, nop_row);
                        exp_pc += 32'd4;
                end

                $display("checks: %0d, errors: %0d", check_count, error_count);
                if (error_count == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- src.f
logic/arm_decode_pkg.sv
logic/fetch_unit.sv
logic/instr_queue.sv
logic/arm_decoder.sv
logic/decode_frontend.sv
verification/decode_frontend_tb.sv

//--- Bender.yml
package:
  name: decode_frontend

sources:
  - files:
      - logic/arm_decode_pkg.sv
      - logic/fetch_unit.sv
      - logic/instr_queue.sv
      - logic/arm_decoder.sv
      - logic/decode_frontend.sv
  - target: test
    files:
      - verification/decode_frontend_tb.sv
